/* axil_rd_bridge.f */
hdl/axil_rd_bridge_pkg.sv
hdl/axi_burst_iter_ar.sv
hdl/axil_tag_fifo.sv
hdl/axil_reflect_rd.sv
hdl/axi_axil_bridge_rd.sv
verif/tb_clk_gen.sv
verif/axil_rd_bridge_checker.sv
verif/axil_rd_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the AXI to AXI-Lite read bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f axil_rd_bridge.f \
  --top-module axil_rd_bridge_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vaxil_rd_bridge_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

/* verif/axil_rd_bridge_trace.txt */
// kind_id_addr_len_size_burst for kind 1, a burst command (burst 0 FIXED, 1 INCR, 2 WRAP)
// kind_id_addr_00_0_last for kind 2, an expected R beat in arrival order
1_1_0100_05_2_1
2_1_0100_00_0_0
2_1_0104_00_0_0
2_1_0108_00_0_0
2_1_010c_00_0_0
2_1_0110_00_0_0
2_1_0114_00_0_1
1_2_0200_02_2_0
2_2_0200_00_0_0
2_2_0200_00_0_0
2_2_0200_00_0_1
1_3_0308_03_2_2
2_3_0308_00_0_0
2_3_030c_00_0_0
2_3_0300_00_0_0
2_3_0304_00_0_1
1_4_7ff8_03_2_1
2_4_7ff8_00_0_0
2_4_7ffc_00_0_0
2_4_8000_00_0_0
2_4_8004_00_0_1
1_7_0040_00_2_1
2_7_0040_00_0_1

/* verif/axil_rd_bridge_tb.sv */
`default_nettype none

// Testbench top for the AXI to AXI-Lite read bridge
module axil_rd_bridge_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TRACE_LINES  = 64;
  localparam int RST_TIMEOUT  = 20;
  localparam int AR_TIMEOUT   = 300;
  localparam int DONE_TIMEOUT = 3000;

  logic        clk;
  logic        rst;
  logic        i_axi_arvalid;
  logic [3:0]  i_axi_arid;
  logic [15:0] i_axi_araddr;
  logic [7:0]  i_axi_arlen;
  logic [2:0]  i_axi_arsize;
  logic [1:0]  i_axi_arburst;
  logic        o_axi_arready;
  logic        o_axi_rvalid;
  logic [3:0]  o_axi_rid;
  logic [31:0] o_axi_rdata;
  logic [1:0]  o_axi_rresp;
  logic        o_axi_rlast;
  logic        i_axi_rready;
  logic        o_axil_arvalid;
  logic [15:0] o_axil_araddr;
  logic        i_axil_arready;
  logic        i_axil_rvalid;
  logic [31:0] i_axil_rdata;
  logic [1:0]  i_axil_rresp;
  logic        o_axil_rready;

  logic [39:0] trace_mem [TRACE_LINES];
  logic [15:0] pend_q [$];
  logic [15:0] ar_addr_snap;
  logic        ar_fire;
  logic        r_fire;
  int          resp_delay;
  int          seed;
  int          tb_errors;
  int          cycles;
  logic        run_end;
  logic        checker_done;
  int          checker_errors;

  tb_clk_gen u_clk_gen (
    .clk  (clk),
    .o_rst(rst)
  );

  axi_axil_bridge_rd u_dut (
    .clk(clk), .i_rst(rst),
    .i_axi_arvalid(i_axi_arvalid), .i_axi_arid(i_axi_arid), .i_axi_araddr(i_axi_araddr),
    .i_axi_arlen(i_axi_arlen), .i_axi_arsize(i_axi_arsize), .i_axi_arburst(i_axi_arburst),
    .o_axi_arready(o_axi_arready), .o_axi_rvalid(o_axi_rvalid), .o_axi_rid(o_axi_rid),
    .o_axi_rdata(o_axi_rdata), .o_axi_rresp(o_axi_rresp), .o_axi_rlast(o_axi_rlast),
    .i_axi_rready(i_axi_rready), .o_axil_arvalid(o_axil_arvalid),
    .o_axil_araddr(o_axil_araddr), .i_axil_arready(i_axil_arready),
    .i_axil_rvalid(i_axil_rvalid), .i_axil_rdata(i_axil_rdata),
    .i_axil_rresp(i_axil_rresp), .o_axil_rready(o_axil_rready)
  );

  axil_rd_bridge_checker #(.TRACE_LINES(TRACE_LINES)) u_checker (
    .clk(clk), .i_rst(rst), .i_rvalid(o_axi_rvalid), .i_rready(i_axi_rready),
    .i_rid(o_axi_rid), .i_rdata(o_axi_rdata), .i_rresp(o_axi_rresp), .i_rlast(o_axi_rlast),
    .i_run_end(run_end), .i_other_errors(tb_errors), .o_done(checker_done),
    .o_errors(checker_errors)
  );

  // Holds one AR request until the bridge accepts it; starts just after an edge
  task automatic send_burst(input logic [3:0] id, input logic [15:0] addr,
                            input logic [7:0] len, input logic [2:0] size,
                            input logic [1:0] burst);
    int   ar_cycles;
    logic accepted;
    i_axi_arvalid = 1'b1;
    i_axi_arid    = id;
    i_axi_araddr  = addr;
    i_axi_arlen   = len;
    i_axi_arsize  = size;
    i_axi_arburst = burst;
    accepted  = 1'b0;
    ar_cycles = 0;
    while (!accepted && ar_cycles < AR_TIMEOUT) begin
      @(negedge clk);
      accepted = o_axi_arready;
      @(posedge clk);
      #1;
      ar_cycles++;
    end
    i_axi_arvalid = 1'b0;
    if (!accepted) begin
      tb_errors++;
      $display("timeout: burst with id %h at %h was never accepted", id, addr);
    end
  endtask

  // AXI-Lite memory with random stalls that also drives RREADY
  initial begin
    seed           = 32'h5f8f;
    resp_delay     = 0;
    i_axil_arready = 1'b0;
    i_axil_rvalid  = 1'b0;
    i_axil_rdata   = '0;
    i_axil_rresp   = '0;
    i_axi_rready   = 1'b0;
    forever begin
      @(negedge clk);
      ar_fire      = o_axil_arvalid && i_axil_arready;
      r_fire       = i_axil_rvalid && o_axil_rready;
      ar_addr_snap = o_axil_araddr;
      @(posedge clk);
      #1;
      if (r_fire) begin
        void'(pend_q.pop_front());
        i_axil_rvalid = 1'b0;
        resp_delay    = $random(seed) & 3;
      end
      if (ar_fire) begin
        pend_q.push_back(ar_addr_snap);
      end
      if (!i_axil_rvalid && pend_q.size() != 0) begin
        if (resp_delay == 0) begin
          i_axil_rvalid = 1'b1;
          i_axil_rdata  = {16'h0000, pend_q[0]} ^ 32'ha5a5_0000;
          i_axil_rresp  = pend_q[0][15] ? axil_rd_bridge_pkg::RESP_SLVERR
                                        : axil_rd_bridge_pkg::RESP_OKAY;
        end else begin
          resp_delay--;
        end
      end
      i_axil_arready = ($random(seed) & 3) != 0;
      i_axi_rready   = ($random(seed) & 3) != 0;
    end
  end

  initial begin
    tb_errors     = 0;
    run_end       = 1'b0;
    i_axi_arvalid = 1'b0;
    i_axi_arid    = '0;
    i_axi_araddr  = '0;
    i_axi_arlen   = '0;
    i_axi_arsize  = '0;
    i_axi_arburst = '0;
    for (int i = 0; i < TRACE_LINES; i++) begin
      trace_mem[i] = '0;
    end
    $readmemh("verif/axil_rd_bridge_trace.txt", trace_mem);
    cycles = 0;
    while (rst !== 1'b0 && cycles < RST_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (rst !== 1'b0) begin
      tb_errors++;
      $display("timeout: reset was never released");
    end
    #1;
    // Commands go out back to back
    for (int i = 0; i < TRACE_LINES; i++) begin
      if (trace_mem[i][39:36] == 4'h1) begin
        send_burst(trace_mem[i][35:32], trace_mem[i][31:16], trace_mem[i][15:8],
                   trace_mem[i][6:4], trace_mem[i][1:0]);
      end
    end
    cycles = 0;
    while (checker_done !== 1'b1 && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (checker_done !== 1'b1) begin
      tb_errors++;
      $display("timeout: not every R beat came back");
    end
    @(posedge clk);
    #1;
    run_end = 1'b1;
    @(posedge clk);
    #1;
    if (tb_errors == 0 && checker_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/axil_rd_bridge_checker.sv */
`default_nettype none

// Compares every R beat with the expected beats listed in the trace
module axil_rd_bridge_checker #(
  parameter int TRACE_LINES = 64
) (
  input  logic                                      clk,
  input  logic                                      i_rst,
  input  logic                                      i_rvalid,
  input  logic                                      i_rready,
  input  logic [3:0]                                i_rid,
  input  logic [31:0]                               i_rdata,
  input  logic [axil_rd_bridge_pkg::RESP_WIDTH-1:0] i_rresp,
  input  logic                                      i_rlast,
  input  logic                                      i_run_end,
  input  int                                        i_other_errors,
  output logic                                      o_done,
  output int                                        o_errors
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [39:0] trace_mem [TRACE_LINES];
  // Expected beat packed as {id, addr, last}
  logic [20:0] exp_q [$];
  logic [20:0] exp_beat;
  logic [31:0] exp_data;
  logic [axil_rd_bridge_pkg::RESP_WIDTH-1:0] exp_resp;
  int burst_beats = 0;
  int beats_seen = 0;
  int value_errors = 0;
  logic reported = 1'b0;

  initial begin
    for (int i = 0; i < TRACE_LINES; i++) begin
      trace_mem[i] = '0;
    end
    $readmemh("verif/axil_rd_bridge_trace.txt", trace_mem);
    for (int i = 0; i < TRACE_LINES; i++) begin
      if (trace_mem[i][39:36] == 4'h1) begin
        burst_beats += int'(trace_mem[i][15:8]) + 1;
      end else if (trace_mem[i][39:36] == 4'h2) begin
        exp_q.push_back({trace_mem[i][35:16], trace_mem[i][0]});
      end
    end
  end

  // Values at the falling edge hold through the next rising edge
  always @(negedge clk) begin
    if (!i_rst && i_rvalid && i_rready) begin
      if (exp_q.size() == 0) begin
        value_errors++;
        $display("error %0t: R beat with rid %h beyond the expected beats", $time, i_rid);
      end else begin
        exp_beat = exp_q.pop_front();
        exp_data = {16'h0000, exp_beat[16:1]} ^ 32'ha5a5_0000;
        exp_resp = exp_beat[16] ? axil_rd_bridge_pkg::RESP_SLVERR
                                : axil_rd_bridge_pkg::RESP_OKAY;
        if (i_rid !== exp_beat[20:17] || i_rdata !== exp_data ||
            i_rresp !== exp_resp || i_rlast !== exp_beat[0]) begin
          value_errors++;
          $display("error %0t: beat %0d got id %h data %h resp %h last %b, expected %h %h %h %b",
                   $time, beats_seen, i_rid, i_rdata, i_rresp, i_rlast,
                   exp_beat[20:17], exp_data, exp_resp, exp_beat[0]);
        end
      end
      beats_seen++;
    end
    o_done <= (burst_beats > 0) && (beats_seen == burst_beats);
    if (i_run_end && !reported) begin
      reported = 1'b1;
      if (beats_seen != burst_beats || exp_q.size() != 0) begin
        value_errors++;
        $display("error %0t: %0d beats returned, bursts asked for %0d, %0d expected left",
                 $time, beats_seen, burst_beats, exp_q.size());
      end
      $display("beats checked %0d, value errors %0d, other failures %0d",
               beats_seen, value_errors, i_other_errors);
    end
  end

  assign o_errors = value_errors;

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`default_nettype none

// Free-running clock and a reset held for the first few cycles
module tb_clk_gen #(
  parameter int HALF_PERIOD = 2,
  parameter int RST_CYCLES  = 4
) (
  output logic clk,
  output logic o_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Release lands just after an edge, like the rest of the stimulus
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    o_rst = 1'b0;
  end

endmodule

`default_nettype wire

/* hdl/axi_axil_bridge_rd.sv */
`default_nettype none

// AXI to AXI-Lite read bridge, same data width on both sides
module axi_axil_bridge_rd #(
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int TAG_DEPTH  = 4
) (
  input  logic                                        clk,
  input  logic                                        i_rst,

  // AXI subordinate, read only
  input  logic                                        i_axi_arvalid,
  input  logic [ID_WIDTH-1:0]                         i_axi_arid,
  input  logic [ADDR_WIDTH-1:0]                       i_axi_araddr,
  input  logic [axil_rd_bridge_pkg::LEN_WIDTH-1:0]    i_axi_arlen,
  input  logic [axil_rd_bridge_pkg::SIZE_WIDTH-1:0]   i_axi_arsize,
  input  logic [axil_rd_bridge_pkg::BURST_WIDTH-1:0]  i_axi_arburst,
  output logic                                        o_axi_arready,
  output logic                                        o_axi_rvalid,
  output logic [ID_WIDTH-1:0]                         o_axi_rid,
  output logic [DATA_WIDTH-1:0]                       o_axi_rdata,
  output logic [axil_rd_bridge_pkg::RESP_WIDTH-1:0]   o_axi_rresp,
  output logic                                        o_axi_rlast,
  input  logic                                        i_axi_rready,

  // AXI-Lite manager
  output logic                                        o_axil_arvalid,
  output logic [ADDR_WIDTH-1:0]                       o_axil_araddr,
  input  logic                                        i_axil_arready,
  input  logic                                        i_axil_rvalid,
  input  logic [DATA_WIDTH-1:0]                       i_axil_rdata,
  input  logic [axil_rd_bridge_pkg::RESP_WIDTH-1:0]   i_axil_rresp,
  output logic                                        o_axil_rready
);

  logic                  beat_valid;
  logic [ADDR_WIDTH-1:0] beat_addr;
  logic [ID_WIDTH-1:0]   beat_id;
  logic                  beat_last;
  logic                  beat_ready;

  axi_burst_iter_ar #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) u_burst_iter (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_axi_arvalid(i_axi_arvalid),
    .i_axi_arid   (i_axi_arid),
    .i_axi_araddr (i_axi_araddr),
    .i_axi_arlen  (i_axi_arlen),
    .i_axi_arsize (i_axi_arsize),
    .i_axi_arburst(i_axi_arburst),
    .o_axi_arready(o_axi_arready),
    .o_beat_valid (beat_valid),
    .o_beat_addr  (beat_addr),
    .o_beat_id    (beat_id),
    .o_beat_last  (beat_last),
    .i_beat_ready (beat_ready)
  );

  axil_reflect_rd #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH),
    .TAG_DEPTH (TAG_DEPTH)
  ) u_reflect (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_beat_valid  (beat_valid),
    .i_beat_addr   (beat_addr),
    .i_beat_id     (beat_id),
    .i_beat_last   (beat_last),
    .o_beat_ready  (beat_ready),
    .o_axil_arvalid(o_axil_arvalid),
    .o_axil_araddr (o_axil_araddr),
    .i_axil_arready(i_axil_arready),
    .i_axil_rvalid (i_axil_rvalid),
    .i_axil_rdata  (i_axil_rdata),
    .i_axil_rresp  (i_axil_rresp),
    .o_axil_rready (o_axil_rready),
    .o_axi_rvalid  (o_axi_rvalid),
    .o_axi_rid     (o_axi_rid),
    .o_axi_rdata   (o_axi_rdata),
    .o_axi_rresp   (o_axi_rresp),
    .o_axi_rlast   (o_axi_rlast),
    .i_axi_rready  (i_axi_rready)
  );

endmodule

`default_nettype wire

/* hdl/axil_reflect_rd.sv */
`default_nettype none

// Issues one AXI-Lite read per beat and tags the returned data
module axil_reflect_rd #(
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int TAG_DEPTH  = 4
) (
  input  logic                                      clk,
  input  logic                                      i_rst,

  // Beats from the iterator
  input  logic                                      i_beat_valid,
  input  logic [ADDR_WIDTH-1:0]                     i_beat_addr,
  input  logic [ID_WIDTH-1:0]                       i_beat_id,
  input  logic                                      i_beat_last,
  output logic                                      o_beat_ready,

  // AXI-Lite manager side
  output logic                                      o_axil_arvalid,
  output logic [ADDR_WIDTH-1:0]                     o_axil_araddr,
  input  logic                                      i_axil_arready,
  input  logic                                      i_axil_rvalid,
  input  logic [DATA_WIDTH-1:0]                     i_axil_rdata,
  input  logic [axil_rd_bridge_pkg::RESP_WIDTH-1:0] i_axil_rresp,
  output logic                                      o_axil_rready,

  // AXI R channel
  output logic                                      o_axi_rvalid,
  output logic [ID_WIDTH-1:0]                       o_axi_rid,
  output logic [DATA_WIDTH-1:0]                     o_axi_rdata,
  output logic [axil_rd_bridge_pkg::RESP_WIDTH-1:0] o_axi_rresp,
  output logic                                      o_axi_rlast,
  input  logic                                      i_axi_rready
);

  localparam int TAG_WIDTH = ID_WIDTH + 1;

  logic                 tag_full;
  logic                 tag_empty;
  logic                 tag_push;
  logic                 tag_pop;
  logic [TAG_WIDTH-1:0] tag_push_data;
  logic [TAG_WIDTH-1:0] tag_pop_data;

  // AR side, stalled while every tag slot is in use
  assign o_axil_arvalid = i_beat_valid && !tag_full;
  assign o_axil_araddr  = i_beat_addr;
  assign o_beat_ready   = i_axil_arready && !tag_full;

  assign tag_push      = o_axil_arvalid && i_axil_arready;
  assign tag_push_data = {i_beat_id, i_beat_last};

  // R side is a pure pass-through
  assign o_axi_rvalid  = i_axil_rvalid;
  assign o_axi_rdata   = i_axil_rdata;
  assign o_axi_rresp   = i_axil_rresp;
  assign o_axil_rready = i_axi_rready;

  // AXI-Lite returns in order, so the oldest tag matches
  assign {o_axi_rid, o_axi_rlast} = tag_pop_data;
  assign tag_pop = i_axil_rvalid && i_axi_rready;

  axil_tag_fifo #(
    .WIDTH(TAG_WIDTH),
    .DEPTH(TAG_DEPTH)
  ) u_tag_fifo (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_push     (tag_push),
    .i_push_data(tag_push_data),
    .i_pop      (tag_pop),
    .o_pop_data (tag_pop_data),
    .o_full     (tag_full),
    .o_empty    (tag_empty)
  );

  // Read data only for reads this bridge has issued
  a_rvalid_has_tag: assert property (
    @(posedge clk) disable iff (i_rst)
    i_axil_rvalid |-> !tag_empty
  );

endmodule

`default_nettype wire

/* hdl/axil_tag_fifo.sv */
`default_nettype none

// Small synchronous FIFO for the tags of outstanding reads
module axil_tag_fifo #(
  parameter int WIDTH = 5,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             i_rst,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_push_data,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_pop_data,
  output logic             o_full,
  output logic             o_empty
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);
  localparam logic [PTR_WIDTH-1:0] LAST_PTR  = PTR_WIDTH'(DEPTH - 1);
  localparam logic [CNT_WIDTH-1:0] FULL_CNT  = CNT_WIDTH'(DEPTH);
  localparam logic [CNT_WIDTH-1:0] CNT_ONE   = CNT_WIDTH'(1);

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;

  // Oldest entry always visible
  assign o_pop_data = mem[rd_ptr];
  assign o_full     = (count == FULL_CNT);
  assign o_empty    = (count == '0);

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count unchanged
      case ({i_push, i_pop})
        2'b10:   count <= count + CNT_ONE;
        2'b01:   count <= count - CNT_ONE;
        default: count <= count;
      endcase
    end
  end

  a_no_push_full: assert property (
    @(posedge clk) disable iff (i_rst) i_push |-> !o_full
  );

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (i_rst) i_pop |-> !o_empty
  );

endmodule

`default_nettype wire

/* hdl/axi_burst_iter_ar.sv */
`default_nettype none

// Splits one AXI read burst into single beat addresses
module axi_burst_iter_ar #(
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4
) (
  input  logic                                        clk,
  input  logic                                        i_rst,

  // AXI AR channel, held by the manager until o_axi_arready
  input  logic                                        i_axi_arvalid,
  input  logic [ID_WIDTH-1:0]                         i_axi_arid,
  input  logic [ADDR_WIDTH-1:0]                       i_axi_araddr,
  input  logic [axil_rd_bridge_pkg::LEN_WIDTH-1:0]    i_axi_arlen,
  input  logic [axil_rd_bridge_pkg::SIZE_WIDTH-1:0]   i_axi_arsize,
  input  logic [axil_rd_bridge_pkg::BURST_WIDTH-1:0]  i_axi_arburst,
  output logic                                        o_axi_arready,

  // Beat channel
  output logic                                        o_beat_valid,
  output logic [ADDR_WIDTH-1:0]                       o_beat_addr,
  output logic [ID_WIDTH-1:0]                         o_beat_id,
  output logic                                        o_beat_last,
  input  logic                                        i_beat_ready
);

  localparam logic [ADDR_WIDTH-1:0] ADDR_ONE = ADDR_WIDTH'(1);
  localparam logic [axil_rd_bridge_pkg::LEN_WIDTH-1:0] LEN_ONE =
    axil_rd_bridge_pkg::LEN_WIDTH'(1);

  // Set once the first beat has transferred, cleared after the last
  logic                                     busy;
  logic [axil_rd_bridge_pkg::LEN_WIDTH-1:0] beat_cnt;
  logic [ADDR_WIDTH-1:0]                    cur_addr;

  logic [axil_rd_bridge_pkg::LEN_WIDTH-1:0] beat_idx;
  logic                                     beat_xfer;
  logic [ADDR_WIDTH-1:0]                    size_bytes;
  logic [ADDR_WIDTH-1:0]                    align_mask;
  logic [ADDR_WIDTH-1:0]                    incr_addr;
  logic [ADDR_WIDTH-1:0]                    wrap_mask;
  logic [ADDR_WIDTH-1:0]                    next_addr;

  // First beat comes straight from the AR inputs
  assign beat_idx     = busy ? beat_cnt : '0;
  assign o_beat_valid = i_axi_arvalid;
  assign o_beat_addr  = busy ? cur_addr : i_axi_araddr;
  assign o_beat_id    = i_axi_arid;
  assign o_beat_last  = (beat_idx == i_axi_arlen);

  assign beat_xfer     = o_beat_valid && i_beat_ready;
  // AR is accepted only when the whole burst has been issued
  assign o_axi_arready = beat_xfer && o_beat_last;

  assign size_bytes = ADDR_ONE << i_axi_arsize;
  assign align_mask = size_bytes - ADDR_ONE;

  // Later beats of an unaligned start land on size boundaries
  assign incr_addr = (o_beat_addr & ~align_mask) + size_bytes;

  // Wrap window is size times beat count, always a power of two
  assign wrap_mask = ((ADDR_WIDTH'(i_axi_arlen) + ADDR_ONE) << i_axi_arsize) - ADDR_ONE;

  always_comb begin
    case (i_axi_arburst)
      axil_rd_bridge_pkg::BURST_FIXED: begin
        next_addr = o_beat_addr;
      end
      axil_rd_bridge_pkg::BURST_WRAP: begin
        next_addr = (o_beat_addr & ~wrap_mask) | (incr_addr & wrap_mask);
      end
      // INCR, reserved code treated the same
      default: begin
        next_addr = incr_addr;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      busy     <= 1'b0;
      beat_cnt <= '0;
    end else if (beat_xfer) begin
      busy     <= !o_beat_last;
      beat_cnt <= o_beat_last ? '0 : beat_idx + LEN_ONE;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_xfer) begin
      cur_addr <= next_addr;
    end
  end

  // Beat size must fit the data bus
  a_size_fits_bus: assert property (
    @(posedge clk) disable iff (i_rst)
    i_axi_arvalid |-> ((32'd8 << i_axi_arsize) <= DATA_WIDTH)
  );

  // WRAP lengths limited to 2, 4, 8 or 16 beats
  a_wrap_len: assert property (
    @(posedge clk) disable iff (i_rst)
    (i_axi_arvalid && i_axi_arburst == axil_rd_bridge_pkg::BURST_WRAP) |->
      (i_axi_arlen inside {8'd1, 8'd3, 8'd7, 8'd15})
  );

  // Beats after the first read the AR payload, so it must hold until accepted
  a_ar_hold: assert property (
    @(posedge clk) disable iff (i_rst)
    (i_axi_arvalid && !o_axi_arready) |=>
      (i_axi_arvalid && $stable(i_axi_araddr) && $stable(i_axi_arlen) &&
       $stable(i_axi_arsize) && $stable(i_axi_arburst) && $stable(i_axi_arid))
  );

endmodule

`default_nettype wire

/* hdl/axil_rd_bridge_pkg.sv */
`default_nettype none

package axil_rd_bridge_pkg;

  // AXI field widths
  localparam int LEN_WIDTH   = 8;
  localparam int SIZE_WIDTH  = 3;
  localparam int BURST_WIDTH = 2;
  localparam int RESP_WIDTH  = 2;

  // Burst type codes
  localparam logic [BURST_WIDTH-1:0] BURST_FIXED = 2'b00;
  localparam logic [BURST_WIDTH-1:0] BURST_INCR  = 2'b01;
  localparam logic [BURST_WIDTH-1:0] BURST_WRAP  = 2'b10;

  // Response codes
  localparam logic [RESP_WIDTH-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
